//--- Bender.yml
package:
  name: execute_stage

sources:
  - common/execute_pkg.sv
  - rtl/int_alu.sv
  - rtl/branch_unit.sv
  - divider/serial_divider.sv
  - execute/execute_stage.sv
  - rtl/execute_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_execute.sv

//--- all.f
+incdir+tests
common/execute_pkg.sv
rtl/int_alu.sv
rtl/branch_unit.sv
divider/serial_divider.sv
execute/execute_stage.sv
rtl/execute_top.sv
tests/tb_execute.sv

//--- common/execute_pkg.sv
package execute_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // widths and codes
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int xlen = 32;

  typedef enum logic [4:0] {
    op_nop,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_sltu,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu,
    op_div,
    op_divu,
    op_rem,
    op_remu,
    op_ecall,
    op_ebreak,
    op_illegal
  } exec_op_e;

  // no exception uses a code outside the machine causes.
  typedef enum logic [3:0] {
    cause_none             = 4'd15,
    cause_misaligned_fetch = 4'd0,
    cause_illegal          = 4'd2,
    cause_breakpoint       = 4'd3,
    cause_ecall_m          = 4'd11
  } ecause_e;

  typedef enum logic [1:0] {
    div_idle,
    div_busy,
    div_done
  } div_state_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // operation classes
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic is_branch(exec_op_e op);
    return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
  endfunction

  function automatic logic is_div(exec_op_e op);
    return op inside {op_div, op_divu, op_rem, op_remu};
  endfunction

  function automatic logic writes_rd(exec_op_e op);
    return !(is_branch(op) || (op inside {op_nop, op_ecall, op_ebreak, op_illegal}));
  endfunction

endpackage

//--- divider/serial_divider.sv
`timescale 1ns/1ns

module serial_divider #(
  parameter int XLEN = execute_pkg::xlen
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  cancel,
  input  execute_pkg::exec_op_e op,
  input  logic [XLEN-1:0]       dividend,
  input  logic [XLEN-1:0]       divisor,
  output logic [XLEN-1:0]       result,
  output logic                  ready
);

  import execute_pkg::*;

  localparam int count_width = $clog2(XLEN);

  div_state_e state;
  logic [count_width-1:0] count;
  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] dvsr;
  logic [XLEN:0] rem_shift;
  logic [XLEN:0] diff;
  logic signed_op;
  logic sign_a;
  logic sign_b;
  logic want_rem;
  logic neg_quo;
  logic neg_rem;

  assign signed_op = (op == op_div) || (op == op_rem);
  assign sign_a = signed_op & dividend[XLEN-1];
  assign sign_b = signed_op & divisor[XLEN-1];

  // one restoring step.
  assign rem_shift = {rem, quo[XLEN-1]};
  assign diff = rem_shift - {1'b0, dvsr};

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      state <= div_idle;
      ready <= 1'b0;
    end else if (cancel) begin
      state <= div_idle;
      ready <= 1'b0;
    end else begin
      case (state)
        div_idle: begin
          if (start) begin
            state <= div_busy;
            ready <= 1'b0;
          end
        end
        div_busy: begin
          if (count == count_width'(XLEN - 1)) begin
            state <= div_done;
          end
        end
        default: begin
          state <= div_idle;
          ready <= 1'b1;
        end
      endcase
    end
  end

  // a zero divisor leaves all ones in quo and the dividend in rem.
  // signed overflow falls out of the magnitude path unchanged.
  always_ff @(posedge clock) begin
    if (state == div_idle && start) begin
      quo <= sign_a ? -dividend : dividend;
      dvsr <= sign_b ? -divisor : divisor;
      rem <= '0;
      count <= '0;
      want_rem <= (op == op_rem) || (op == op_remu);
      neg_quo <= (sign_a ^ sign_b) & (divisor != '0);
      neg_rem <= sign_a;
    end else if (state == div_busy) begin
      rem <= diff[XLEN] ? rem_shift[XLEN-1:0] : diff[XLEN-1:0];
      quo <= {quo[XLEN-2:0], ~diff[XLEN]};
      count <= count + 1'b1;
    end else if (state == div_done) begin
      if (want_rem) begin
        result <= neg_rem ? -rem : rem;
      end else begin
        result <= neg_quo ? -quo : quo;
      end
    end
  end

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/1ns

module execute_stage #(
  parameter int XLEN = execute_pkg::xlen
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  hold,
  input  logic                  valid_0,
  input  execute_pkg::exec_op_e op_0,
  input  logic [XLEN-1:0]       rdata1_0, rdata2_0, imm_0,
  input  logic [XLEN-1:0]       pc_0, npc_0, instr_0,
  input  logic                  valid_1,
  input  execute_pkg::exec_op_e op_1,
  input  logic [XLEN-1:0]       rdata1_1, rdata2_1, imm_1,
  input  logic [XLEN-1:0]       pc_1, npc_1, instr_1,
  input  logic [XLEN-1:0]       alu0_result, alu1_result,
  input  logic                  branch_taken,
  input  logic [XLEN-1:0]       div_result,
  input  logic                  div_ready,
  output logic                  branch_enable,
  output execute_pkg::exec_op_e branch_op,
  output logic [XLEN-1:0]       branch_rdata1, branch_rdata2,
  output logic                  div_start, div_cancel,
  output execute_pkg::exec_op_e div_op,
  output logic [XLEN-1:0]       div_dividend, div_divisor,
  output logic                  stall,
  output logic                  q_valid_0, q_wren_0, q_jump_0, q_exception_0,
  output logic [XLEN-1:0]       q_wdata_0, q_target_0, q_etval_0,
  output execute_pkg::ecause_e  q_ecause_0,
  output logic                  q_valid_1, q_wren_1, q_jump_1, q_exception_1,
  output logic [XLEN-1:0]       q_wdata_1, q_target_1, q_etval_1,
  output execute_pkg::ecause_e  q_ecause_1
);

  import execute_pkg::*;

  exec_op_e op [2];
  logic valid [2];
  logic live [2];
  logic [XLEN-1:0] rdata1 [2];
  logic [XLEN-1:0] rdata2 [2];
  logic [XLEN-1:0] imm [2];
  logic [XLEN-1:0] pc [2];
  logic [XLEN-1:0] npc [2];
  logic [XLEN-1:0] instr [2];
  logic [XLEN-1:0] alu_result [2];
  logic [XLEN-1:0] target [2];
  logic [XLEN-1:0] wdata [2];
  logic [XLEN-1:0] etval [2];
  ecause_e cause [2];
  logic jump [2];
  logic wren [2];
  logic exc [2];
  logic br_owner;
  logic div_owner;
  logic div_need;
  logic div_issued;
  logic accept;

  logic r_valid [2];
  logic r_wren [2];
  logic r_jump [2];
  logic r_exc [2];
  logic [XLEN-1:0] r_wdata [2];
  logic [XLEN-1:0] r_target [2];
  logic [XLEN-1:0] r_etval [2];
  ecause_e r_cause [2];

  assign valid = '{valid_0, valid_1};
  assign op = '{op_0, op_1};
  assign rdata1 = '{rdata1_0, rdata1_1};
  assign rdata2 = '{rdata2_0, rdata2_1};
  assign imm = '{imm_0, imm_1};
  assign pc = '{pc_0, pc_1};
  assign npc = '{npc_0, npc_1};
  assign instr = '{instr_0, instr_1};
  assign alu_result = '{alu0_result, alu1_result};

  // ~~~~~~~~~~~~~~~~~~~~
  // shared branch unit, slot 0 first.
  assign br_owner = ~(valid[0] & is_branch(op[0]));
  assign branch_enable = (valid[0] & is_branch(op[0])) | (valid[1] & is_branch(op[1]));
  assign branch_op = op[br_owner];
  assign branch_rdata1 = rdata1[br_owner];
  assign branch_rdata2 = rdata2[br_owner];

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      if (op[s] == op_jalr) begin
        target[s] = (rdata1[s] + imm[s]) & ~XLEN'(1);
      end else begin
        target[s] = pc[s] + imm[s];
      end
      jump[s] = (op[s] == op_jal) || (op[s] == op_jalr) ||
                (branch_taken && (br_owner == 1'(s)));
      wren[s] = writes_rd(op[s]);
      if ((op[s] == op_jal) || (op[s] == op_jalr)) begin
        wdata[s] = npc[s];
      end else if (is_div(op[s])) begin
        wdata[s] = div_result;
      end else begin
        wdata[s] = alu_result[s];
      end
      // highest priority first.
      exc[s] = 1'b1;
      etval[s] = instr[s];
      if (op[s] == op_illegal) begin
        cause[s] = cause_illegal;
      end else if (op[s] == op_ebreak) begin
        cause[s] = cause_breakpoint;
      end else if (op[s] == op_ecall) begin
        cause[s] = cause_ecall_m;
      end else if (jump[s] && (target[s][1:0] != 2'b00)) begin
        cause[s] = cause_misaligned_fetch;
        etval[s] = target[s];
        jump[s] = 1'b0;
        wren[s] = 1'b0;
      end else begin
        exc[s] = 1'b0;
        cause[s] = cause_none;
        etval[s] = '0;
      end
    end
  end

  // slot 1 is dropped when it sits on the fall-through path of a redirect.
  assign live[0] = valid[0];
  assign live[1] = valid[1] & ~(valid[0] & (exc[0] | jump[0]) & (npc[0] == pc[1]));

  // ~~~~~~~~~~~~~~~~~~~~
  // shared divider.
  assign div_owner = ~(live[0] & is_div(op[0]));
  assign div_need = (live[0] & is_div(op[0])) | (live[1] & is_div(op[1]));
  assign div_op = op[div_owner];
  assign div_dividend = rdata1[div_owner];
  assign div_divisor = rdata2[div_owner];
  assign div_cancel = clear;
  assign div_start = div_need & ~div_issued & ~hold & ~clear;
  assign stall = div_need & ~(div_issued & div_ready) & ~clear;
  assign accept = ~clear & ~hold & ~stall;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      div_issued <= 1'b0;
      for (int s = 0; s < 2; s++) begin
        r_valid[s] <= 1'b0;
        r_wren[s] <= 1'b0;
        r_jump[s] <= 1'b0;
        r_exc[s] <= 1'b0;
      end
    end else begin
      if (clear || accept) begin
        div_issued <= 1'b0;
      end else if (div_start) begin
        div_issued <= 1'b1;
      end
      for (int s = 0; s < 2; s++) begin
        if (clear || (stall && !hold)) begin
          r_valid[s] <= 1'b0;
          r_wren[s] <= 1'b0;
          r_jump[s] <= 1'b0;
          r_exc[s] <= 1'b0;
        end else if (!hold) begin
          r_valid[s] <= live[s];
          r_wren[s] <= live[s] & wren[s];
          r_jump[s] <= live[s] & jump[s];
          r_exc[s] <= live[s] & exc[s];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      for (int s = 0; s < 2; s++) begin
        r_wdata[s] <= wdata[s];
        r_target[s] <= target[s];
        r_etval[s] <= etval[s];
        r_cause[s] <= cause[s];
      end
    end
  end

  assign q_valid_0 = r_valid[0];
  assign q_wren_0 = r_wren[0];
  assign q_jump_0 = r_jump[0];
  assign q_exception_0 = r_exc[0];
  assign q_wdata_0 = r_wdata[0];
  assign q_target_0 = r_target[0];
  assign q_etval_0 = r_etval[0];
  assign q_ecause_0 = r_cause[0];
  assign q_valid_1 = r_valid[1];
  assign q_wren_1 = r_wren[1];
  assign q_jump_1 = r_jump[1];
  assign q_exception_1 = r_exc[1];
  assign q_wdata_1 = r_wdata[1];
  assign q_target_1 = r_target[1];
  assign q_etval_1 = r_etval[1];
  assign q_ecause_1 = r_cause[1];

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit #(
  parameter int XLEN = execute_pkg::xlen
) (
  input  logic                  enable,
  input  execute_pkg::exec_op_e op,
  input  logic [XLEN-1:0]       rdata1,
  input  logic [XLEN-1:0]       rdata2,
  output logic                  taken
);

  import execute_pkg::*;

  always_comb begin
    taken = 1'b0;
    if (enable) begin
      case (op)
        op_beq:  taken = (rdata1 == rdata2);
        op_bne:  taken = (rdata1 != rdata2);
        op_blt:  taken = ($signed(rdata1) < $signed(rdata2));
        op_bge:  taken = ($signed(rdata1) >= $signed(rdata2));
        op_bltu: taken = (rdata1 < rdata2);
        op_bgeu: taken = (rdata1 >= rdata2);
        default: taken = 1'b0;
      endcase
    end
  end

endmodule

//--- rtl/execute_top.sv
`timescale 1ns/1ns

module execute_top #(
  parameter int XLEN = execute_pkg::xlen
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  hold,
  input  logic                  valid_0, use_imm_0,
  input  execute_pkg::exec_op_e op_0,
  input  logic [XLEN-1:0]       rdata1_0, rdata2_0, imm_0,
  input  logic [XLEN-1:0]       pc_0, npc_0, instr_0,
  input  logic                  valid_1, use_imm_1,
  input  execute_pkg::exec_op_e op_1,
  input  logic [XLEN-1:0]       rdata1_1, rdata2_1, imm_1,
  input  logic [XLEN-1:0]       pc_1, npc_1, instr_1,
  output logic                  stall,
  output logic                  q_valid_0, q_wren_0, q_jump_0, q_exception_0,
  output logic [XLEN-1:0]       q_wdata_0, q_target_0, q_etval_0,
  output execute_pkg::ecause_e  q_ecause_0,
  output logic                  q_valid_1, q_wren_1, q_jump_1, q_exception_1,
  output logic [XLEN-1:0]       q_wdata_1, q_target_1, q_etval_1,
  output execute_pkg::ecause_e  q_ecause_1
);

  import execute_pkg::*;

  logic [XLEN-1:0] alu0_result;
  logic [XLEN-1:0] alu1_result;
  logic branch_enable;
  exec_op_e branch_op;
  logic [XLEN-1:0] branch_rdata1;
  logic [XLEN-1:0] branch_rdata2;
  logic branch_taken;
  logic div_start;
  logic div_cancel;
  exec_op_e div_op;
  logic [XLEN-1:0] div_dividend;
  logic [XLEN-1:0] div_divisor;
  logic [XLEN-1:0] div_result;
  logic div_ready;

  int_alu #(.XLEN(XLEN)) alu0 (
    .op(op_0),
    .use_imm(use_imm_0),
    .rdata1(rdata1_0),
    .rdata2(rdata2_0),
    .imm(imm_0),
    .pc(pc_0),
    .result(alu0_result)
  );

  int_alu #(.XLEN(XLEN)) alu1 (
    .op(op_1),
    .use_imm(use_imm_1),
    .rdata1(rdata1_1),
    .rdata2(rdata2_1),
    .imm(imm_1),
    .pc(pc_1),
    .result(alu1_result)
  );

  branch_unit #(.XLEN(XLEN)) branch (
    .enable(branch_enable),
    .op(branch_op),
    .rdata1(branch_rdata1),
    .rdata2(branch_rdata2),
    .taken(branch_taken)
  );

  serial_divider #(.XLEN(XLEN)) divider (
    .clock(clock),
    .reset(reset),
    .start(div_start),
    .cancel(div_cancel),
    .op(div_op),
    .dividend(div_dividend),
    .divisor(div_divisor),
    .result(div_result),
    .ready(div_ready)
  );

  // names match one to one.
  execute_stage #(.XLEN(XLEN)) stage (.*);

endmodule

//--- rtl/int_alu.sv
`timescale 1ns/1ns

module int_alu #(
  parameter int XLEN = execute_pkg::xlen
) (
  input  execute_pkg::exec_op_e op,
  input  logic                  use_imm,
  input  logic [XLEN-1:0]       rdata1,
  input  logic [XLEN-1:0]       rdata2,
  input  logic [XLEN-1:0]       imm,
  input  logic [XLEN-1:0]       pc,
  output logic [XLEN-1:0]       result
);

  import execute_pkg::*;

  localparam int shift_width = $clog2(XLEN);

  logic [XLEN-1:0] operand2;
  logic [shift_width-1:0] shamt;

  // i-type forms take the immediate.
  assign operand2 = use_imm ? imm : rdata2;
  assign shamt = operand2[shift_width-1:0];

  always_comb begin
    case (op)
      op_add:   result = rdata1 + operand2;
      op_sub:   result = rdata1 - operand2;
      op_and:   result = rdata1 & operand2;
      op_or:    result = rdata1 | operand2;
      op_xor:   result = rdata1 ^ operand2;
      op_sll:   result = rdata1 << shamt;
      op_srl:   result = rdata1 >> shamt;
      op_sra:   result = $signed(rdata1) >>> shamt;
      op_slt:   result = XLEN'($signed(rdata1) < $signed(operand2));
      op_sltu:  result = XLEN'(rdata1 < operand2);
      // upper immediates arrive already shifted.
      op_lui:   result = imm;
      op_auipc: result = pc + imm;
      default:  result = '0;
    endcase
  end

endmodule

//--- tests/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// operation classes
// ~~~~~~~~~~~~~~~~~~~~

function automatic logic cond_branch_op(input exec_op_e op);
  return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
endfunction

function automatic logic divide_op(input exec_op_e op);
  return op inside {op_div, op_divu, op_rem, op_remu};
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// reference arithmetic
// ~~~~~~~~~~~~~~~~~~~~

function automatic logic [xlen-1:0] alu_value(input exec_op_e op,
    input logic [xlen-1:0] a, b, imm, pc);
  int sh;
  sh = int'(b % xlen);
  case (op)
    op_add:   return a + b;
    op_sub:   return a - b;
    op_and:   return a & b;
    op_or:    return a | b;
    op_xor:   return a ^ b;
    op_sll:   return a << sh;
    op_srl:   return a >> sh;
    op_sra:   return $signed(a) >>> sh;
    op_slt:   return ($signed(a) < $signed(b)) ? 1 : 0;
    op_sltu:  return (a < b) ? 1 : 0;
    op_lui:   return imm;
    op_auipc: return pc + imm;
    default:  return '0;
  endcase
endfunction

function automatic logic branch_cond(input exec_op_e op, input logic [xlen-1:0] a, b);
  case (op)
    op_beq:  return a == b;
    op_bne:  return a != b;
    op_blt:  return $signed(a) < $signed(b);
    op_bge:  return $signed(a) >= $signed(b);
    op_bltu: return a < b;
    op_bgeu: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// risc-v results for a zero divisor and for signed overflow.
function automatic logic [xlen-1:0] div_value(input exec_op_e op, input logic [xlen-1:0] a, b);
  logic [xlen-1:0] most_neg;
  most_neg = {1'b1, {(xlen-1){1'b0}}};
  if (b == '0) begin
    return (op inside {op_div, op_divu}) ? '1 : a;
  end
  if ((a == most_neg) && (b == '1) && (op inside {op_div, op_rem})) begin
    return (op == op_div) ? a : '0;
  end
  case (op)
    op_div:  return $signed(a) / $signed(b);
    op_divu: return a / b;
    op_rem:  return $signed(a) % $signed(b);
    default: return a % b;
  endcase
endfunction

task automatic predict_slot(input exec_op_e op, input logic use_imm,
    input logic [xlen-1:0] r1, r2, imm, pc, npc, instr,
    output logic wren, jump, exc, output ecause_e cause,
    output logic [xlen-1:0] wdata, target, etval);
  logic linking;
  logic [xlen-1:0] sum;
  linking = (op == op_jal) || (op == op_jalr);
  sum = r1 + imm;
  target = (op == op_jalr) ? {sum[xlen-1:1], 1'b0} : pc + imm;
  jump = linking || (cond_branch_op(op) && branch_cond(op, r1, r2));
  wren = !(cond_branch_op(op) || (op inside {op_nop, op_ecall, op_ebreak, op_illegal}));
  if (linking) begin
    wdata = npc;
  end else if (divide_op(op)) begin
    wdata = div_value(op, r1, r2);
  end else begin
    wdata = alu_value(op, r1, use_imm ? imm : r2, imm, pc);
  end
  exc = 1'b1;
  etval = instr;
  if (op == op_illegal) begin
    cause = cause_illegal;
  end else if (op == op_ebreak) begin
    cause = cause_breakpoint;
  end else if (op == op_ecall) begin
    cause = cause_ecall_m;
  end else if (jump && (target[1:0] != 2'b00)) begin
    cause = cause_misaligned_fetch;
    etval = target;
    jump = 1'b0;
    wren = 1'b0;
  end else begin
    exc = 1'b0;
    cause = cause_none;
    etval = '0;
  end
endtask

`endif

//--- tests/tb_execute.sv
`timescale 1ns/1ns

module tb_execute;

  import execute_pkg::*;

  `include "exec_model.svh"

  logic clock;
  logic reset;
  logic clear;
  logic hold;
  logic stall;
  logic [1:0] in_valid;
  logic [1:0] in_use_imm;
  exec_op_e in_op [2];
  logic [1:0][xlen-1:0] in_rdata1, in_rdata2, in_imm;
  logic [1:0][xlen-1:0] in_pc, in_npc, in_instr;

  wire [1:0] q_valid, q_wren, q_jump, q_exc;
  wire [1:0][xlen-1:0] q_wdata, q_target, q_etval;
  wire [1:0][3:0] q_ecause;

  // expected register contents, and the prediction for the pair on the inputs.
  logic [1:0] e_valid, e_wren, e_jump, e_exc;
  logic [1:0][xlen-1:0] e_wdata, e_target, e_etval;
  ecause_e e_cause [2];
  logic [1:0] p_valid, p_wren, p_jump, p_exc;
  logic [1:0][xlen-1:0] p_wdata, p_target, p_etval;
  ecause_e p_cause [2];
  logic pair_div;

  execute_top #(.XLEN(xlen)) UUT (
    .clock(clock), .reset(reset), .clear(clear), .hold(hold),
    .valid_0(in_valid[0]), .use_imm_0(in_use_imm[0]), .op_0(in_op[0]),
    .rdata1_0(in_rdata1[0]), .rdata2_0(in_rdata2[0]), .imm_0(in_imm[0]),
    .pc_0(in_pc[0]), .npc_0(in_npc[0]), .instr_0(in_instr[0]),
    .valid_1(in_valid[1]), .use_imm_1(in_use_imm[1]), .op_1(in_op[1]),
    .rdata1_1(in_rdata1[1]), .rdata2_1(in_rdata2[1]), .imm_1(in_imm[1]),
    .pc_1(in_pc[1]), .npc_1(in_npc[1]), .instr_1(in_instr[1]),
    .stall(stall),
    .q_valid_0(q_valid[0]), .q_wren_0(q_wren[0]), .q_jump_0(q_jump[0]),
    .q_exception_0(q_exc[0]), .q_wdata_0(q_wdata[0]), .q_target_0(q_target[0]),
    .q_etval_0(q_etval[0]), .q_ecause_0(q_ecause[0]),
    .q_valid_1(q_valid[1]), .q_wren_1(q_wren[1]), .q_jump_1(q_jump[1]),
    .q_exception_1(q_exc[1]), .q_wdata_1(q_wdata[1]), .q_target_1(q_target[1]),
    .q_etval_1(q_etval[1]), .q_ecause_1(q_ecause[1])
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_word(input string name, input logic [xlen-1:0] got, expected);
    if (got !== expected) begin
      $display("MISMATCH %s got %h expected %h", name, got, expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_cause(input string name, input ecause_e got, expected);
    if (got !== expected) begin
      $display("MISMATCH %s got %h expected %h", name, got, expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic got, expected);
    if (got !== expected) begin
      $display("MISMATCH %s got %h expected %h", name, got, expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_outputs();
    for (int s = 0; s < 2; s++) begin
      check_flag($sformatf("q_valid_%0d", s), q_valid[s], e_valid[s]);
      check_flag($sformatf("q_wren_%0d", s), q_wren[s], e_wren[s]);
      check_flag($sformatf("q_jump_%0d", s), q_jump[s], e_jump[s]);
      check_flag($sformatf("q_exception_%0d", s), q_exc[s], e_exc[s]);
      if (e_valid[s]) begin
        check_word($sformatf("q_target_%0d", s), q_target[s], e_target[s]);
        check_cause($sformatf("q_ecause_%0d", s), ecause_e'(q_ecause[s]), e_cause[s]);
        if (e_wren[s]) begin
          check_word($sformatf("q_wdata_%0d", s), q_wdata[s], e_wdata[s]);
        end
        if (e_exc[s]) begin
          check_word($sformatf("q_etval_%0d", s), q_etval[s], e_etval[s]);
        end
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  // corner values make zero divisors, overflow and equal compares common.
  function automatic logic [xlen-1:0] pick_operand();
    case ($urandom % 8)
      0:       return '0;
      1:       return {1'b1, {(xlen-1){1'b0}}};
      2:       return '1;
      3:       return $urandom % 4;
      default: return $urandom;
    endcase
  endfunction

  task automatic make_pair();
    for (int s = 0; s < 2; s++) begin
      in_valid[s] = ($urandom % 5) != 0;
      in_op[s] = exec_op_e'($urandom % 28);
      in_use_imm[s] = $urandom % 2;
      in_rdata1[s] = pick_operand();
      in_rdata2[s] = pick_operand();
      in_imm[s] = $urandom;
      if (($urandom % 4) != 0) begin
        in_imm[s][1:0] = 2'b00;
      end
      in_instr[s] = $urandom;
    end
    // one branch and one divide per pair at most.
    if (cond_branch_op(in_op[0]) && cond_branch_op(in_op[1])) begin
      in_op[1] = op_xor;
    end
    if (divide_op(in_op[0]) && divide_op(in_op[1])) begin
      in_op[1] = op_sub;
    end
    in_pc[0] = {$urandom} & ~32'h3;
    in_npc[0] = in_pc[0] + 4;
    in_pc[1] = (($urandom % 4) != 0) ? in_npc[0] : ({$urandom} & ~32'h3);
    in_npc[1] = in_pc[1] + 4;
  endtask

  task automatic predict_pair();
    for (int s = 0; s < 2; s++) begin
      predict_slot(in_op[s], in_use_imm[s], in_rdata1[s], in_rdata2[s], in_imm[s],
                   in_pc[s], in_npc[s], in_instr[s], p_wren[s], p_jump[s], p_exc[s],
                   p_cause[s], p_wdata[s], p_target[s], p_etval[s]);
    end
    // slot 1 on the fall-through path of a redirect is dropped.
    p_valid[0] = in_valid[0];
    p_valid[1] = in_valid[1] &&
                 !(in_valid[0] && (p_exc[0] || p_jump[0]) && (in_npc[0] == in_pc[1]));
    p_wren = p_wren & p_valid;
    p_jump = p_jump & p_valid;
    p_exc = p_exc & p_valid;
    pair_div = (p_valid[0] && divide_op(in_op[0])) || (p_valid[1] && divide_op(in_op[1]));
  endtask

  task automatic expect_bubbles();
    e_valid = '0;
    e_wren = '0;
    e_jump = '0;
    e_exc = '0;
  endtask

  task automatic run_pair();
    int cycles;
    int stalled;
    logic done;
    make_pair();
    predict_pair();
    done = 1'b0;
    cycles = 0;
    stalled = 0;
    while (!done) begin
      if (cycles == 100) begin
        $display("stall did not fall within 100 cycles");
        $display("Testbench failed");
        $fatal(1);
      end
      hold = ($urandom % 10) == 0;
      clear = ($urandom % 33) == 0;
      @(negedge clock);
      if (clear || !pair_div) begin
        check_flag("stall", stall, 1'b0);
      end else if (cycles == 0) begin
        check_flag("stall", stall, 1'b1);
      end
      // the divide starts on the first stalled cycle without hold.
      if (stall && (!hold || (stalled > 0))) begin
        stalled++;
      end
      if (clear) begin
        expect_bubbles();
        done = 1'b1;
      end else if (!hold && stall) begin
        expect_bubbles();
      end else if (!hold) begin
        if (pair_div && (stalled != xlen + 2)) begin
          $display("divide accepted after %0d stalled cycles instead of %0d",
                   stalled, xlen + 2);
          $display("Testbench failed");
          $fatal(1);
        end
        e_valid = p_valid;
        e_wren = p_wren;
        e_jump = p_jump;
        e_exc = p_exc;
        e_wdata = p_wdata;
        e_target = p_target;
        e_etval = p_etval;
        e_cause = p_cause;
        done = 1'b1;
      end
      @(posedge clock);
      #1;
      check_outputs();
      #1;
      cycles++;
    end
  endtask

  initial begin
    void'($urandom(32'hd1631c53));
    reset = 1'b0;
    clear = 1'b0;
    hold = 1'b0;
    in_valid = '0;
    in_use_imm = '0;
    in_op[0] = op_nop;
    in_op[1] = op_nop;
    in_rdata1 = '0;
    in_rdata2 = '0;
    in_imm = '0;
    in_pc = '0;
    in_npc = '0;
    in_instr = '0;
    expect_bubbles();
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b1;
    @(negedge clock);
    check_flag("stall", stall, 1'b0);
    check_outputs();
    @(posedge clock);
    #2;
    for (int n = 0; n < 3000; n++) begin
      run_pair();
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
